// ==== rtl/mips_mem_pkg.sv ====
`default_nettype none

package mips_mem_pkg;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [19:0] pfn_t;
    typedef logic [2:0]  cca_t;

    typedef enum logic [2:0] {
        op_none,
        op_load,
        op_store,
        op_ll,
        op_sc
    } mem_op_e;

    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word
    } mem_size_e;

    // swl / swr only matter for stores
    typedef enum logic [1:0] {
        st_plain,
        st_left,
        st_right
    } store_kind_e;

    typedef struct packed {
        mem_op_e     op;
        mem_size_e   size;
        store_kind_e store_kind;
        vaddr_t      vaddr;
        logic [31:0] rt_data;
        vaddr_t      pc;
    } mem_req_t;

    typedef struct packed {
        logic found;
        logic valid;
        logic dirty;
        pfn_t pfn;
        cca_t cca;
    } tlb_resp_t;

    typedef struct packed {
        paddr_t paddr;
        logic   mapped;
        logic   uncached;
    } addr_info_t;

    typedef struct packed {
        logic [3:0]  wstrb;
        logic [31:0] wdata;
    } store_out_t;

    // vaddr[31:29]
    localparam logic [2:0] kseg0_top = 3'b100;
    localparam logic [2:0] kseg1_top = 3'b101;

endpackage

`default_nettype wire

// ==== rtl/mips_exc_pkg.sv ====
`default_nettype none

package mips_exc_pkg;

    typedef logic [4:0] exc_code_t;

    // cause.exccode values
    localparam exc_code_t exc_int  = 5'd0;
    localparam exc_code_t exc_mod  = 5'd1;
    localparam exc_code_t exc_tlbl = 5'd2;
    localparam exc_code_t exc_tlbs = 5'd3;
    localparam exc_code_t exc_adel = 5'd4;
    localparam exc_code_t exc_ades = 5'd5;
    localparam exc_code_t exc_ov   = 5'd12;
    localparam exc_code_t exc_tr   = 5'd13;

    typedef struct packed {
        logic        raise;
        exc_code_t   code;
        logic [31:0] badvaddr; // 0 for int/ov/tr
    } exc_info_t;

endpackage

`default_nettype wire

// ==== rtl/mem_addr_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_addr_decode
    import mips_mem_pkg::*;
#(
    parameter cca_t CACHED_CCA = 3'd3
) (
    input  mem_req_t   req,
    input  tlb_resp_t  tlb,
    input  cca_t       k0_cca,
    output addr_info_t addr
);

    logic [2:0] seg;
    logic       in_kseg0;
    logic       in_kseg1;
    logic       mapped;
    logic       uncached;
    paddr_t     paddr;

    assign seg      = req.vaddr[31:29];
    assign in_kseg0 = (seg == kseg0_top);
    assign in_kseg1 = (seg == kseg1_top);

    // kuseg, kseg2 and kseg3 go through the tlb
    assign mapped = ~req.vaddr[31] | (req.vaddr[31] & req.vaddr[30]);

    always_comb begin
        if (mapped) begin
            paddr = {tlb.pfn, req.vaddr[11:0]};
        end else begin
            paddr = {3'b000, req.vaddr[28:0]};
        end
    end

    always_comb begin
        if (in_kseg1) begin
            uncached = 1'b1;
        end else if (in_kseg0) begin
            uncached = (k0_cca != CACHED_CCA); // Config.K0
        end else begin
            uncached = (tlb.cca != CACHED_CCA); // page attribute
        end
    end

    assign addr.paddr    = paddr;
    assign addr.mapped   = mapped;
    assign addr.uncached = uncached;

endmodule

`default_nettype wire

// ==== rtl/mem_exc_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_exc_ctrl
    import mips_mem_pkg::*;
    import mips_exc_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  mem_req_t   req,
    input  tlb_resp_t  tlb,
    input  addr_info_t addr,
    input  logic       interrupt,
    input  logic       overflow,
    input  logic       trap,
    input  logic       prior_exc,
    input  logic       eret_flush,
    input  exc_code_t  prior_code,
    output exc_info_t  exc,
    output logic       store_en,
    output logic       dm_en,
    output vaddr_t     sc_result
);

    logic   is_load;
    logic   is_write;
    logic   misaligned;
    logic   ades;
    logic   adel;
    logic   tlb_miss;
    logic   tlb_mod;
    logic   raise;
    logic   ll_bit;
    vaddr_t ll_addr;
    logic   sc_ok;
    logic   sc_pass;

    assign is_load  = (req.op == op_load) | (req.op == op_ll);
    assign is_write = (req.op == op_store) | (req.op == op_sc);

    always_comb begin
        case (req.size)
            size_half: misaligned = req.vaddr[0];
            size_word: misaligned = (req.vaddr[1:0] != 2'b00);
            default:   misaligned = 1'b0;
        endcase
    end

    // swl/swr take any offset
    assign ades = misaligned & ((req.op == op_sc) |
                  ((req.op == op_store) & (req.store_kind == st_plain)));
    assign adel = misaligned & is_load;

    // refill and invalid share one code
    assign tlb_miss = addr.mapped & (req.op != op_none) & (~tlb.found | ~tlb.valid);
    assign tlb_mod  = addr.mapped & is_write & tlb.found & tlb.valid & ~tlb.dirty;

    assign raise = interrupt | prior_exc | overflow | trap | ades | adel | tlb_miss | tlb_mod;

    always_comb begin
        exc.raise    = raise;
        exc.code     = exc_int;
        exc.badvaddr = req.vaddr;
        if (interrupt) begin
            exc.badvaddr = '0;
        end else if (prior_exc) begin
            exc.code     = prior_code;
            exc.badvaddr = req.pc; // raised upstream, report its pc
        end else if (overflow) begin
            exc.code     = exc_ov;
            exc.badvaddr = '0;
        end else if (trap) begin
            exc.code     = exc_tr;
            exc.badvaddr = '0;
        end else if (ades) begin
            exc.code = exc_ades;
        end else if (adel) begin
            exc.code = exc_adel;
        end else if (tlb_miss) begin
            exc.code = is_write ? exc_tlbs : exc_tlbl;
        end else if (tlb_mod) begin
            exc.code = exc_mod;
        end
    end

    // link state for ll/sc
    always_ff @(posedge clk) begin
        if (!rst_n || raise || eret_flush) begin
            ll_bit  <= 1'b0;
            ll_addr <= '0;
        end else if (req.op == op_ll) begin
            ll_bit  <= 1'b1;
            ll_addr <= req.vaddr;
        end
    end

    assign sc_ok   = ll_bit & (ll_addr == req.vaddr);
    assign sc_pass = (req.op == op_sc) & sc_ok;

    assign store_en  = (req.op == op_store) | sc_pass;
    assign dm_en     = (req.op != op_none) & ~raise & ~eret_flush &
                       ((req.op != op_sc) | sc_ok);
    assign sc_result = {31'b0, sc_pass};

endmodule

`default_nettype wire

// ==== rtl/store_align.sv ====
`timescale 1ns/100ps
`default_nettype none

module store_align
    import mips_mem_pkg::*;
(
    input  mem_req_t   req,
    input  addr_info_t addr,
    input  logic       store_en,
    output store_out_t st
);

    logic [1:0]  off;
    logic [3:0]  lanes;
    logic [31:0] wdata;

    assign off = addr.paddr[1:0];

    // byte lanes before the write gate
    always_comb begin
        case (req.store_kind)
            st_left: begin
                case (off)
                    2'd0:    lanes = 4'b0001;
                    2'd1:    lanes = 4'b0011;
                    2'd2:    lanes = 4'b0111;
                    default: lanes = 4'b1111;
                endcase
            end
            st_right: begin
                case (off)
                    2'd0:    lanes = 4'b1111;
                    2'd1:    lanes = 4'b1110;
                    2'd2:    lanes = 4'b1100;
                    default: lanes = 4'b1000;
                endcase
            end
            default: begin
                case (req.size)
                    size_byte: lanes = 4'b0001 << off;
                    size_half: lanes = off[1] ? 4'b1100 : 4'b0011;
                    default:   lanes = 4'b1111;
                endcase
            end
        endcase
    end

    always_comb begin
        case (req.store_kind)
            st_left:  wdata = req.rt_data >> {~off, 3'b000}; // 3 - off bytes
            st_right: wdata = req.rt_data << {off, 3'b000};
            default: begin
                case (req.size)
                    size_byte: wdata = {4{req.rt_data[7:0]}};
                    size_half: wdata = {2{req.rt_data[15:0]}};
                    default:   wdata = req.rt_data;
                endcase
            end
        endcase
    end

    assign st.wstrb = store_en ? lanes : 4'b0000;
    assign st.wdata = wdata;

endmodule

`default_nettype wire

// ==== rtl/mem1_access_prep.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem1_access_prep
    import mips_mem_pkg::*;
    import mips_exc_pkg::*;
#(
    parameter cca_t CACHED_CCA = 3'd3
) (
    input  logic       clk,
    input  logic       rst_n,
    input  mem_req_t   req,
    input  tlb_resp_t  tlb,
    input  cca_t       k0_cca,
    input  logic       interrupt,
    input  logic       overflow,
    input  logic       trap,
    input  logic       prior_exc,
    input  exc_code_t  prior_code,
    input  logic       eret_flush,
    output addr_info_t addr,
    output exc_info_t  exc,
    output logic       dm_en,
    output vaddr_t     sc_result,
    output store_out_t st
);

    logic store_en; // store or successful sc

    mem_addr_decode #(
        .CACHED_CCA (CACHED_CCA)
    ) u_decode (
        .req    (req),
        .tlb    (tlb),
        .k0_cca (k0_cca),
        .addr   (addr)
    );

    mem_exc_ctrl u_exc (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .tlb        (tlb),
        .addr       (addr),
        .interrupt  (interrupt),
        .overflow   (overflow),
        .trap       (trap),
        .prior_exc  (prior_exc),
        .eret_flush (eret_flush),
        .prior_code (prior_code),
        .exc        (exc),
        .store_en   (store_en),
        .dm_en      (dm_en),
        .sc_result  (sc_result)
    );

    store_align u_store (
        .req      (req),
        .addr     (addr),
        .store_en (store_en),
        .st       (st)
    );

endmodule

`default_nettype wire

// ==== verification/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// kseg0 and kseg1 bypass the tlb, everything else is mapped
function automatic addr_info_t ref_addr(input mem_req_t r, input tlb_resp_t t, input cca_t k0);
    addr_info_t a;
    a.mapped = (r.vaddr[31:29] != kseg0_top) && (r.vaddr[31:29] != kseg1_top);
    a.paddr  = a.mapped ? {t.pfn, r.vaddr[11:0]} : (r.vaddr & 32'h1fff_ffff);
    if (r.vaddr[31:29] == kseg1_top) begin
        a.uncached = 1'b1;
    end else if (r.vaddr[31:29] == kseg0_top) begin
        a.uncached = (k0 != CACHED_CCA);
    end else begin
        a.uncached = (t.cca != CACHED_CCA);
    end
    return a;
endfunction

function automatic exc_info_t ref_exc(input mem_req_t r, input tlb_resp_t t,
                                      input logic mapped, input side_in_t s);
    exc_info_t e;
    logic      wr;
    logic      mis;
    logic      ades;
    logic      adel;
    logic      tlb_bad;
    logic      tlb_mod;
    wr      = (r.op == op_store) || (r.op == op_sc);
    mis     = (r.size == size_word) ? (r.vaddr[1:0] != 2'b00)
                                    : ((r.size == size_half) && r.vaddr[0]);
    ades    = mis && ((r.op == op_sc) || (r.op == op_store && r.store_kind == st_plain));
    adel    = mis && ((r.op == op_load) || (r.op == op_ll));
    tlb_bad = mapped && (r.op != op_none) && !(t.found && t.valid);
    tlb_mod = mapped && wr && t.found && t.valid && !t.dirty;
    e       = '0;
    e.raise = s.interrupt || s.prior_exc || s.overflow || s.trap ||
              ades || adel || tlb_bad || tlb_mod;
    e.badvaddr = r.vaddr; // address and tlb faults
    if (s.interrupt) begin
        e.code     = exc_int;
        e.badvaddr = '0;
    end else if (s.prior_exc) begin
        e.code     = s.prior_code;
        e.badvaddr = r.pc;
    end else if (s.overflow || s.trap) begin
        e.code     = s.overflow ? exc_ov : exc_tr;
        e.badvaddr = '0;
    end else if (ades) begin
        e.code = exc_ades;
    end else if (adel) begin
        e.code = exc_adel;
    end else if (tlb_bad) begin
        e.code = wr ? exc_tlbs : exc_tlbl;
    end else if (tlb_mod) begin
        e.code = exc_mod;
    end
    return e;
endfunction

function automatic logic ref_sc_ok(input mem_req_t r, input logic ll_bit, input vaddr_t ll_addr);
    return ll_bit && (ll_addr == r.vaddr);
endfunction

function automatic store_out_t ref_store(input mem_req_t r, input logic [1:0] off,
                                         input logic sc_ok);
    store_out_t s;
    if (r.store_kind == st_left) begin
        s.wstrb = 4'b1111 >> (3 - off);
        s.wdata = r.rt_data >> (8 * (3 - off));
    end else if (r.store_kind == st_right) begin
        s.wstrb = 4'b1111 << off;
        s.wdata = r.rt_data << (8 * off);
    end else if (r.size == size_byte) begin
        s.wstrb      = 4'b0000;
        s.wstrb[off] = 1'b1; // one lane per offset
        s.wdata = {4{r.rt_data[7:0]}};
    end else if (r.size == size_half) begin
        s.wstrb = off[1] ? 4'b1100 : 4'b0011;
        s.wdata = {2{r.rt_data[15:0]}};
    end else begin
        s.wstrb = 4'b1111;
        s.wdata = r.rt_data;
    end
    if (!((r.op == op_store) || (r.op == op_sc && sc_ok))) begin
        s.wstrb = 4'b0000; // nothing may be written
    end
    return s;
endfunction

function automatic logic ref_dm_en(input mem_req_t r, input logic raise, input logic flush,
                                   input logic sc_ok);
    return (r.op != op_none) && !raise && !flush && ((r.op != op_sc) || sc_ok);
endfunction

function automatic vaddr_t ref_sc_result(input mem_req_t r, input logic sc_ok);
    return ((r.op == op_sc) && sc_ok) ? 32'd1 : 32'd0;
endfunction

`endif

// ==== verification/tb_mem1_access_prep.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_mem1_access_prep
    import mips_mem_pkg::*;
    import mips_exc_pkg::*;
();

    typedef struct packed {
        logic      interrupt;
        logic      prior_exc;
        logic      overflow;
        logic      trap;
        logic      eret_flush;
        exc_code_t prior_code;
    } side_in_t;

    localparam cca_t CACHED_CCA = 3'd3;
    localparam int   CLK_PERIOD = 20;
    localparam int   MAX_CYCLES = 2000;

    logic       clk = 1'b0;
    logic       rst_n;
    mem_req_t   req;
    tlb_resp_t  tlb;
    cca_t       k0_cca;
    side_in_t   side;
    addr_info_t addr;
    exc_info_t  exc;
    logic       dm_en;
    vaddr_t     sc_result;
    store_out_t st;

    logic [15:0] lfsr_state = 16'd3;
    logic        shadow_ll_bit = 1'b0;
    vaddr_t      shadow_ll_addr = '0;
    int          n_driven = 0;
    int          n_checked = 0;
    int          sc_pass_seen = 0;
    int          sc_fail_seen = 0;

    `include "tb_ref_model.svh"

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[14:0],
                          lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic mem_size_e size_of(input int k);
        return (k == 0) ? size_byte : (k == 1) ? size_half : size_word;
    endfunction

    function automatic mem_req_t rand_req(input mem_op_e op);
        mem_req_t r;
        logic [1:0] k;
        r.op       = op;
        r.size     = size_of(rand_bits(2));
        k          = 2'(rand_bits(2));
        r.store_kind = (op != op_store) ? st_plain : (k == 1) ? st_left :
                       (k == 2) ? st_right : st_plain;
        r.vaddr    = rand_bits(32);
        r.rt_data  = rand_bits(32);
        r.pc       = rand_bits(30) << 2;
        return r;
    endfunction

    function automatic tlb_resp_t rand_tlb();
        tlb_resp_t t;
        t.found = (rand_bits(3) != 0);
        t.valid = (rand_bits(3) != 0);
        t.dirty = (rand_bits(2) != 0);
        t.pfn   = pfn_t'(rand_bits(20));
        t.cca   = cca_t'(rand_bits(3));
        return t;
    endfunction

    function automatic vaddr_t kseg0_addr(input logic [1:0] off);
        vaddr_t a;
        a        = rand_bits(32);
        a[31:29] = kseg0_top;
        a[1:0]   = off;
        return a;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_addr(input addr_info_t exp, input addr_info_t act);
        if (exp !== act) begin
            abort_run($sformatf("FAIL addr: expected %h, got %h", exp, act));
        end
    endtask

    task automatic check_exc(input exc_info_t exp, input exc_info_t act);
        if (exp.raise !== act.raise) begin
            abort_run($sformatf("FAIL exc.raise: expected %h, got %h", exp.raise, act.raise));
        end else if (exp.raise && (exp !== act)) begin
            abort_run($sformatf("FAIL exc: expected %h, got %h", exp, act));
        end
    endtask

    task automatic check_store(input store_out_t exp, input store_out_t act);
        if (exp !== act) begin
            abort_run($sformatf("FAIL st: expected %h, got %h", exp, act));
        end
    endtask

    task automatic check_flags(input logic exp_dm, input logic act_dm,
                               input vaddr_t exp_sc, input vaddr_t act_sc);
        if (exp_dm !== act_dm) begin
            abort_run($sformatf("FAIL dm_en: expected %h, got %h", exp_dm, act_dm));
        end else if (exp_sc !== act_sc) begin
            abort_run($sformatf("FAIL sc_result: expected %h, got %h", exp_sc, act_sc));
        end
    endtask

    task automatic drive(input mem_req_t r, input tlb_resp_t t, input cca_t k0,
                         input side_in_t s);
        @(negedge clk);
        req    = r;
        tlb    = t;
        k0_cca = k0;
        side   = s;
        n_driven++;
    endtask

    mem1_access_prep #(
        .CACHED_CCA (CACHED_CCA)
    ) u_mem1_access_prep (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .tlb        (tlb),
        .k0_cca     (k0_cca),
        .interrupt  (side.interrupt),
        .overflow   (side.overflow),
        .trap       (side.trap),
        .prior_exc  (side.prior_exc),
        .prior_code (side.prior_code),
        .eret_flush (side.eret_flush),
        .addr       (addr),
        .exc        (exc),
        .dm_en      (dm_en),
        .sc_result  (sc_result),
        .st         (st)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : watchdog
        repeat (MAX_CYCLES) @(posedge clk);
        abort_run("the run went past its cycle limit");
    end

    // scoreboard, 1 ns before each rising edge
    initial begin : compare_proc
        addr_info_t exp_addr;
        exc_info_t  exp_exc;
        store_out_t exp_st;
        logic       exp_ok;
        forever begin
            @(negedge clk);
            #(CLK_PERIOD / 2 - 1);
            exp_addr = ref_addr(req, tlb, k0_cca);
            exp_exc  = ref_exc(req, tlb, exp_addr.mapped, side);
            exp_ok   = ref_sc_ok(req, shadow_ll_bit, shadow_ll_addr);
            exp_st   = ref_store(req, exp_addr.paddr[1:0], exp_ok);
            if (rst_n) begin
                check_addr(exp_addr, addr);
                check_exc(exp_exc, exc);
                check_store(exp_st, st);
                check_flags(ref_dm_en(req, exp_exc.raise, side.eret_flush, exp_ok), dm_en,
                            ref_sc_result(req, exp_ok), sc_result);
                n_checked++;
                if (req.op == op_sc && exp_ok) sc_pass_seen++;
                if (req.op == op_sc && !exp_ok) sc_fail_seen++;
            end
            // link state as the coming edge leaves it
            if (!rst_n || exp_exc.raise || side.eret_flush) begin
                shadow_ll_bit  = 1'b0;
                shadow_ll_addr = '0;
            end else if (req.op == op_ll) begin
                shadow_ll_bit  = 1'b1;
                shadow_ll_addr = req.vaddr;
            end
        end
    end

    initial begin : main_proc
        mem_req_t  r;
        tlb_resp_t good;
        side_in_t  s;
        vaddr_t    a;
        int        timeout;
        req    = '0;
        tlb    = '0;
        k0_cca = CACHED_CCA;
        side   = '0;
        rst_n  = 1'b0;
        good   = '{found: 1'b1, valid: 1'b1, dirty: 1'b1, pfn: 20'h1a2b3, cca: CACHED_CCA};
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        n_driven++; // idle cycle right after reset

        // translation in every segment
        for (int i = 0; i < 160; i++) begin
            drive(rand_req(op_load), rand_tlb(), (i % 2) ? CACHED_CCA : cca_t'(rand_bits(3)), '0);
        end

        // exception priority, random ops and side inputs
        for (int i = 0; i < 300; i++) begin
            s.interrupt  = (rand_bits(3) == 0);
            s.prior_exc  = (rand_bits(3) == 0);
            s.overflow   = (rand_bits(3) == 0);
            s.trap       = (rand_bits(3) == 0);
            s.eret_flush = (rand_bits(3) == 0);
            s.prior_code = exc_code_t'(rand_bits(5));
            case (rand_bits(3) % 5)
                0:       r = rand_req(op_none);
                1:       r = rand_req(op_load);
                2:       r = rand_req(op_store);
                3:       r = rand_req(op_ll);
                default: r = rand_req(op_sc);
            endcase
            drive(r, rand_tlb(), CACHED_CCA, s);
        end

        // plain stores and loads at every offset, then swl and swr
        for (int k = 0; k < 3; k++) begin
            for (int off = 0; off < 4; off++) begin
                r       = rand_req(op_store);
                r.size  = size_of(k);
                r.store_kind = st_plain;
                r.vaddr = kseg0_addr(off[1:0]);
                drive(r, good, CACHED_CCA, '0);
                r.op    = op_load;
                drive(r, good, CACHED_CCA, '0);
            end
        end
        for (int off = 0; off < 8; off++) begin
            r       = rand_req(op_store);
            r.store_kind = (off < 4) ? st_left : st_right;
            r.vaddr = kseg0_addr(off[1:0]);
            drive(r, good, CACHED_CCA, '0);
        end

        // ll/sc sequences on one word
        s = '0;
        s.eret_flush = 1'b1;
        drive('0, good, CACHED_CCA, s); // start with the link cleared
        r       = rand_req(op_sc);
        r.size  = size_word;
        r.vaddr = kseg0_addr(2'd0);
        drive(r, good, CACHED_CCA, '0); // no ll yet
        for (int seq = 0; seq < 4; seq++) begin
            r.op = op_ll;
            drive(r, good, CACHED_CCA, '0);
            if (seq == 1) drive('0, good, CACHED_CCA, s);
            if (seq == 2) drive('0, good, CACHED_CCA, '{interrupt: 1'b1, default: '0});
            r.op = op_sc;
            a    = r.vaddr;
            if (seq == 3) r.vaddr = a + 32'd4;
            drive(r, good, CACHED_CCA, '0);
            r.vaddr = a;
        end

        timeout = 0;
        while (n_checked < n_driven && timeout < 10) begin
            @(posedge clk);
            timeout++;
        end
        if (n_checked < n_driven) begin
            abort_run("the scoreboard did not check every driven cycle in time");
        end else if (sc_pass_seen == 0 || sc_fail_seen == 0) begin
            abort_run("the run did not see both a succeeding and a failing SC");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+verification
rtl/mips_mem_pkg.sv
rtl/mips_exc_pkg.sv
rtl/mem_addr_decode.sv
rtl/mem_exc_ctrl.sv
rtl/store_align.sv
rtl/mem1_access_prep.sv
verification/tb_mem1_access_prep.sv

// ==== Bender.yml ====
package:
  name: mem1_access_prep

sources:
  - rtl/mips_mem_pkg.sv
  - rtl/mips_exc_pkg.sv
  - rtl/mem_addr_decode.sv
  - rtl/mem_exc_ctrl.sv
  - rtl/store_align.sv
  - rtl/mem1_access_prep.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/tb_mem1_access_prep.sv
